// File: ising_pkg.sv
// shared widths, bus structs and encodings of the Ising core
// imported by every RTL block and by the testbench
package ising_pkg;

    localparam int NUM_SPIN = 8;
    localparam int BIT_J    = 4;
    localparam int BIT_H    = 4;
    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 12;
    localparam int FIELD_W  = 8;

    // row i of J sits at JMEM_BASE + 4*i
    localparam logic [ADDR_W-1:0] JMEM_BASE = 12'h100;

    typedef logic [NUM_SPIN-1:0]         spin_vec_t;
    typedef logic [NUM_SPIN*BIT_J-1:0]   j_row_t;
    typedef logic [NUM_SPIN*BIT_H-1:0]   h_vec_t;
    typedef logic [$clog2(NUM_SPIN)-1:0] spin_idx_t;
    typedef logic [7:0]                  sweep_cnt_t;
    typedef logic signed [FIELD_W-1:0]   field_t;

    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } axil_resp_e;

    typedef enum logic [ADDR_W-1:0] {
        REG_CTRL      = 12'h000,
        REG_STATUS    = 12'h004,
        REG_SPIN_INIT = 12'h008,
        REG_H_BIAS    = 12'h00C,
        REG_SPIN_OUT  = 12'h010
    } reg_addr_e;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        UPDATE
    } engine_state_e;

    ////////////////////////////////////////////////////////////
    // host side AXI4-Lite channels
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                aw_valid;
        logic [ADDR_W-1:0]   aw_addr;
        logic                w_valid;
        logic [DATA_W-1:0]   w_data;
        logic [DATA_W/8-1:0] w_strb;
        logic                b_ready;
        logic                ar_valid;
        logic [ADDR_W-1:0]   ar_addr;
        logic                r_ready;
    } axil_req_t;

    typedef struct packed {
        logic              aw_ready;
        logic              w_ready;
        logic              b_valid;
        axil_resp_e        b_resp;
        logic              ar_ready;
        logic              r_valid;
        logic [DATA_W-1:0] r_data;
        axil_resp_e        r_resp;
    } axil_rsp_t;

    // internal single-word bus
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] rdata;
        logic              err;
    } bus_rsp_t;

    typedef struct packed {
        sweep_cnt_t sweeps;
        spin_vec_t  spin_init;
        h_vec_t     h_bias;
    } engine_cfg_t;

endpackage

// File: axil_slave.sv
// AXI4-Lite slave of the Ising core, one transaction at a time
// each accepted read or write becomes one request on the internal bus
`timescale 1ns/100ps

module axil_slave (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  ising_pkg::axil_req_t axil_req_i,
    output ising_pkg::axil_rsp_t axil_rsp_o,
    output ising_pkg::bus_req_t  bus_req_o,
    input  ising_pkg::bus_rsp_t  bus_rsp_i
);
    import ising_pkg::*;

    // set from acceptance until the response handshake
    logic              busy_q;
    logic              wr_q;
    logic              rd_fire;
    logic              wr_fire;
    logic              b_valid_q;
    logic              r_valid_q;
    axil_resp_e        resp_q;
    logic [DATA_W-1:0] rdata_q;

    // reads win when both are pending
    assign rd_fire = axil_req_i.ar_valid && !busy_q;
    assign wr_fire = axil_req_i.aw_valid && axil_req_i.w_valid
                  && !axil_req_i.ar_valid && !busy_q;

    assign axil_rsp_o.ar_ready = rd_fire;
    assign axil_rsp_o.aw_ready = wr_fire;
    assign axil_rsp_o.w_ready  = wr_fire;
    assign axil_rsp_o.b_valid  = b_valid_q;
    assign axil_rsp_o.b_resp   = resp_q;
    assign axil_rsp_o.r_valid  = r_valid_q;
    assign axil_rsp_o.r_data   = rdata_q;
    assign axil_rsp_o.r_resp   = resp_q;

    // request lives in the acceptance cycle only
    assign bus_req_o.valid = rd_fire || wr_fire;
    assign bus_req_o.write = wr_fire;
    assign bus_req_o.addr  = rd_fire ? axil_req_i.ar_addr : axil_req_i.aw_addr;
    assign bus_req_o.wdata = axil_req_i.w_data;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q    <= 1'b0;
            wr_q      <= 1'b0;
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            if (bus_req_o.valid) begin
                busy_q <= 1'b1;
                wr_q   <= wr_fire;
            end
            if (bus_rsp_i.valid) begin
                b_valid_q <= wr_q;
                r_valid_q <= !wr_q;
            end
            if (b_valid_q && axil_req_i.b_ready) begin
                b_valid_q <= 1'b0;
                busy_q    <= 1'b0;
            end
            if (r_valid_q && axil_req_i.r_ready) begin
                r_valid_q <= 1'b0;
                busy_q    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_rsp_i.valid) begin
            resp_q  <= bus_rsp_i.err ? SLVERR : OKAY;
            rdata_q <= bus_rsp_i.rdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // protocol checks
    ////////////////////////////////////////////////////////////
    a_b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        axil_rsp_o.b_valid && !axil_req_i.b_ready
        |=> axil_rsp_o.b_valid && $stable(axil_rsp_o.b_resp));

    a_r_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        axil_rsp_o.r_valid && !axil_req_i.r_ready
        |=> axil_rsp_o.r_valid && $stable(axil_rsp_o.r_data) && $stable(axil_rsp_o.r_resp));

    // register block answers next cycle, nothing new goes out meanwhile
    a_one_req: assert property (@(posedge clk_i) disable iff (reset_i)
        bus_req_o.valid |=> bus_rsp_i.valid && !bus_req_o.valid ##1 !bus_req_o.valid);

endmodule

// File: ising_regs.sv
// control registers and J window decode behind the internal bus
// answers every request one cycle later, err marks a refused access
`timescale 1ns/100ps

module ising_regs (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  ising_pkg::bus_req_t    bus_req_i,
    output ising_pkg::bus_rsp_t    bus_rsp_o,
    output logic                   mem_en_o,
    output logic                   mem_we_o,
    output ising_pkg::spin_idx_t   mem_row_o,
    output ising_pkg::j_row_t      mem_wdata_o,
    input  ising_pkg::j_row_t      mem_rdata_i,
    output ising_pkg::engine_cfg_t cfg_o,
    output logic                   start_o,
    input  logic                   busy_i,
    input  logic                   finish_i,
    input  ising_pkg::spin_vec_t   spin_out_i
);
    import ising_pkg::*;

    localparam int ROW_LSB = 2;
    localparam int WIN_LSB = ROW_LSB + $clog2(NUM_SPIN);

    sweep_cnt_t        sweeps_q;
    spin_vec_t         spin_init_q;
    h_vec_t            h_bias_q;
    logic              start_q;
    logic              done_q;
    logic              busy;
    logic              wr_fire;
    logic              in_jmem;
    logic              addr_err;
    logic [DATA_W-1:0] reg_rdata;
    logic              rsp_valid_q;
    logic              rsp_err_q;
    logic              mem_rd_q;
    logic [DATA_W-1:0] rdata_q;

    // start pulse counts as busy until the engine reports it
    assign busy    = busy_i || start_q;
    assign wr_fire = bus_req_i.valid && bus_req_i.write;
    assign in_jmem = bus_req_i.addr[ADDR_W-1:WIN_LSB] == JMEM_BASE[ADDR_W-1:WIN_LSB]
                  && bus_req_i.addr[ROW_LSB-1:0] == '0;

    // J window, closed while an anneal runs
    assign mem_en_o    = bus_req_i.valid && in_jmem && !busy;
    assign mem_we_o    = bus_req_i.write;
    assign mem_row_o   = bus_req_i.addr[ROW_LSB +: $clog2(NUM_SPIN)];
    assign mem_wdata_o = bus_req_i.wdata;

    always_comb begin
        reg_rdata = '0;
        addr_err  = 1'b0;
        case (bus_req_i.addr)
            REG_CTRL:      reg_rdata = {16'h0, sweeps_q, 8'h0};
            REG_STATUS:    reg_rdata = {30'h0, done_q, busy};
            REG_SPIN_INIT: reg_rdata = {{(DATA_W-NUM_SPIN){1'b0}}, spin_init_q};
            REG_H_BIAS:    reg_rdata = h_bias_q;
            REG_SPIN_OUT:  reg_rdata = {{(DATA_W-NUM_SPIN){1'b0}}, spin_out_i};
            default:       addr_err  = !in_jmem;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sweeps_q    <= '0;
            spin_init_q <= '0;
            h_bias_q    <= '0;
            start_q     <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            start_q <= wr_fire && bus_req_i.addr == REG_CTRL && bus_req_i.wdata[0] && !busy;
            if (wr_fire) begin
                case (bus_req_i.addr)
                    REG_CTRL:      sweeps_q    <= bus_req_i.wdata[15:8];
                    REG_SPIN_INIT: spin_init_q <= bus_req_i.wdata[NUM_SPIN-1:0];
                    REG_H_BIAS:    h_bias_q    <= bus_req_i.wdata;
                    default:       ;
                endcase
            end
            // sticky done
            if (start_q) begin
                done_q <= 1'b0;
            end else if (finish_i) begin
                done_q <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // response
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_q <= 1'b0;
            rsp_err_q   <= 1'b0;
            mem_rd_q    <= 1'b0;
        end else begin
            rsp_valid_q <= bus_req_i.valid;
            rsp_err_q   <= bus_req_i.valid && (in_jmem ? busy : addr_err);
            mem_rd_q    <= mem_en_o && !mem_we_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_req_i.valid) begin
            rdata_q <= reg_rdata;
        end
    end

    // memory row arrives together with the response
    assign bus_rsp_o.valid = rsp_valid_q;
    assign bus_rsp_o.rdata = mem_rd_q ? mem_rdata_i : rdata_q;
    assign bus_rsp_o.err   = rsp_err_q;

    assign cfg_o.sweeps    = sweeps_q;
    assign cfg_o.spin_init = spin_init_q;
    assign cfg_o.h_bias    = h_bias_q;
    assign start_o         = start_q;

    a_no_restart: assert property (@(posedge clk_i) disable iff (reset_i)
        start_o |-> !busy_i);

endmodule

// File: coupling_mem.sv
// J row storage, host port for load and readback, engine port for the anneal
// both ports read with one cycle of latency
`timescale 1ns/100ps

module coupling_mem (
    input  logic                 clk_i,
    input  logic                 host_en_i,
    input  logic                 host_we_i,
    input  ising_pkg::spin_idx_t host_row_i,
    input  ising_pkg::j_row_t    host_wdata_i,
    output ising_pkg::j_row_t    host_rdata_o,
    input  logic                 eng_ren_i,
    input  ising_pkg::spin_idx_t eng_row_i,
    output ising_pkg::j_row_t    eng_rdata_o
);
    import ising_pkg::*;

    j_row_t rows_q [NUM_SPIN];

    always_ff @(posedge clk_i) begin
        if (host_en_i) begin
            if (host_we_i) begin
                rows_q[host_row_i] <= host_wdata_i;
            end else begin
                host_rdata_o <= rows_q[host_row_i];
            end
        end
    end

    // engine port never stalls
    always_ff @(posedge clk_i) begin
        if (eng_ren_i) begin
            eng_rdata_o <= rows_q[eng_row_i];
        end
    end

    // register block keeps the host out while the engine runs
    a_one_port: assert property (@(posedge clk_i) !(host_en_i && eng_ren_i));

endmodule

// File: spin_update_engine.sv
// sequential spin update, one FETCH and one UPDATE cycle per spin
// runs the programmed number of sweeps over all spins, then pulses finish
`timescale 1ns/100ps

module spin_update_engine (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  ising_pkg::engine_cfg_t cfg_i,
    input  logic                   start_i,
    output logic                   mem_ren_o,
    output ising_pkg::spin_idx_t   mem_row_o,
    input  ising_pkg::j_row_t      mem_rdata_i,
    output logic                   busy_o,
    output logic                   finish_o,
    output ising_pkg::spin_vec_t   spins_o
);
    import ising_pkg::*;

    engine_state_e state_q;
    spin_idx_t     idx_q;
    sweep_cnt_t    sweeps_left_q;
    spin_vec_t     spins_q;
    logic          finish_q;
    field_t        field;
    logic          new_bit;
    logic          last_spin;

    assign busy_o    = state_q != IDLE;
    assign mem_ren_o = state_q == FETCH;
    assign mem_row_o = idx_q;
    assign finish_o  = finish_q;
    assign spins_o   = spins_q;
    assign last_spin = idx_q == spin_idx_t'(NUM_SPIN - 1);

    ////////////////////////////////////////////////////////////
    // local field
    ////////////////////////////////////////////////////////////
    // row of spin idx_q is on mem_rdata_i during UPDATE
    always_comb begin : field_calc
        logic signed [BIT_H-1:0] h_i;
        logic signed [BIT_J-1:0] w_j;
        h_i   = cfg_i.h_bias[idx_q*BIT_H +: BIT_H];
        field = field_t'(h_i);
        for (int j = 0; j < NUM_SPIN; j++) begin
            w_j = mem_rdata_i[j*BIT_J +: BIT_J];
            // diagonal weight skipped
            if (spin_idx_t'(j) != idx_q) begin
                field = spins_q[j] ? field + field_t'(w_j) : field - field_t'(w_j);
            end
        end
        new_bit = !field[FIELD_W-1];
    end

    ////////////////////////////////////////////////////////////
    // sweep sequencer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q       <= IDLE;
            idx_q         <= '0;
            sweeps_left_q <= '0;
            spins_q       <= '0;
            finish_q      <= 1'b0;
        end else begin
            finish_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        spins_q       <= cfg_i.spin_init;
                        idx_q         <= '0;
                        sweeps_left_q <= cfg_i.sweeps;
                        // zero sweeps finishes at once
                        if (cfg_i.sweeps == '0) begin
                            finish_q <= 1'b1;
                        end else begin
                            state_q <= FETCH;
                        end
                    end
                end
                FETCH: begin
                    state_q <= UPDATE;
                end
                UPDATE: begin
                    spins_q[idx_q] <= new_bit;
                    idx_q          <= last_spin ? '0 : idx_q + 1'b1;
                    if (last_spin) begin
                        sweeps_left_q <= sweeps_left_q - 1'b1;
                    end
                    if (last_spin && sweeps_left_q == sweep_cnt_t'(1)) begin
                        state_q  <= IDLE;
                        finish_q <= 1'b1;
                    end else begin
                        state_q <= FETCH;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // a start during a sweep would be lost
    a_start_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        start_i |-> !busy_o);

endmodule

// File: ising_core_top.sv
// Ising core top level, AXI4-Lite slave in front of registers, J memory and engine
// host loads J, h and spins, starts an anneal and polls STATUS
`timescale 1ns/100ps

module ising_core_top (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  ising_pkg::axil_req_t axil_req_i,
    output ising_pkg::axil_rsp_t axil_rsp_o
);
    import ising_pkg::*;

    bus_req_t    bus_req;
    bus_rsp_t    bus_rsp;
    logic        host_en;
    logic        host_we;
    spin_idx_t   host_row;
    j_row_t      host_wdata;
    j_row_t      host_rdata;
    engine_cfg_t eng_cfg;
    logic        eng_start;
    logic        eng_busy;
    logic        eng_finish;
    spin_vec_t   eng_spins;
    logic        eng_ren;
    spin_idx_t   eng_row;
    j_row_t      eng_rdata;

    axil_slave u_axil_slave (
        .clk_i      (clk_i      ),
        .reset_i    (reset_i    ),
        .axil_req_i (axil_req_i ),
        .axil_rsp_o (axil_rsp_o ),
        .bus_req_o  (bus_req    ),
        .bus_rsp_i  (bus_rsp    )
    );

    ising_regs u_ising_regs (
        .clk_i       (clk_i      ),
        .reset_i     (reset_i    ),
        .bus_req_i   (bus_req    ),
        .bus_rsp_o   (bus_rsp    ),
        .mem_en_o    (host_en    ),
        .mem_we_o    (host_we    ),
        .mem_row_o   (host_row   ),
        .mem_wdata_o (host_wdata ),
        .mem_rdata_i (host_rdata ),
        .cfg_o       (eng_cfg    ),
        .start_o     (eng_start  ),
        .busy_i      (eng_busy   ),
        .finish_i    (eng_finish ),
        .spin_out_i  (eng_spins  )
    );

    coupling_mem u_coupling_mem (
        .clk_i        (clk_i      ),
        .host_en_i    (host_en    ),
        .host_we_i    (host_we    ),
        .host_row_i   (host_row   ),
        .host_wdata_i (host_wdata ),
        .host_rdata_o (host_rdata ),
        .eng_ren_i    (eng_ren    ),
        .eng_row_i    (eng_row    ),
        .eng_rdata_o  (eng_rdata  )
    );

    spin_update_engine u_spin_update_engine (
        .clk_i       (clk_i      ),
        .reset_i     (reset_i    ),
        .cfg_i       (eng_cfg    ),
        .start_i     (eng_start  ),
        .mem_ren_o   (eng_ren    ),
        .mem_row_o   (eng_row    ),
        .mem_rdata_i (eng_rdata  ),
        .busy_o      (eng_busy   ),
        .finish_o    (eng_finish ),
        .spins_o     (eng_spins  )
    );

endmodule

// File: tb_ising_core.sv
// drives the Ising core over its AXI4-Lite port through a table of anneal cases
// loads J, h and spins, runs each anneal and checks the spins against a reference model
`timescale 1ns/100ps

module tb_ising_core;
    import ising_pkg::*;

    localparam int NUM_CASES   = 6;
    localparam int TXN_LIMIT   = 20;
    localparam int WATCHDOG_NS = NUM_CASES * (64 + 2 * NUM_SPIN * 255 + 200) * 4;

    typedef struct packed {
        spin_vec_t  spin_init;
        h_vec_t     h_bias;
        sweep_cnt_t sweeps;
        logic       rand_j;
    } case_t;

    // initial spins, biases, sweeps and random J per case
    localparam case_t CASE_TBL [NUM_CASES] = '{
        '{8'hA5, 32'h0000_0000, 8'd1,   1'b0},
        '{8'h3C, 32'h1F2E_3D4C, 8'd3,   1'b1},
        '{8'hFF, 32'h8877_0011, 8'd0,   1'b1},
        '{8'h00, 32'h7654_3210, 8'd200, 1'b1},
        '{8'h5A, 32'hF0F0_0F0F, 8'd2,   1'b0},
        '{8'hC3, 32'h1234_ABCD, 8'd5,   1'b1}
    };

    logic        clk_i;
    logic        reset_i;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    logic        wr_acc_q = 1'b0;
    logic        rd_acc_q = 1'b0;
    logic [31:0] lfsr_q;
    j_row_t      j_rows [NUM_SPIN];
    int          errors;

    ising_core_top dut0 (
        .clk_i      (clk_i    ),
        .reset_i    (reset_i  ),
        .axil_req_i (axil_req ),
        .axil_rsp_o (axil_rsp )
    );

    always #2 clk_i = !clk_i;

    // address handshakes seen at the rising edge
    always @(posedge clk_i) begin
        wr_acc_q <= axil_req.aw_valid && axil_req.w_valid
                 && axil_rsp.aw_ready && axil_rsp.w_ready;
        rd_acc_q <= axil_req.ar_valid && axil_rsp.ar_ready;
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic logic [DATA_W-1:0] rand_bits(input int n);
        logic [DATA_W-1:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v      = {v[DATA_W-2:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    // every weight of row i is i+1
    function automatic j_row_t row_pattern(input int i);
        logic [BIT_J-1:0] w;
        w = BIT_J'(i + 1);
        return {NUM_SPIN{w}};
    endfunction

    // sequential update over j_rows with sigma +1 for a set bit
    function automatic spin_vec_t model_anneal(input spin_vec_t init, input h_vec_t h,
                                               input sweep_cnt_t sweeps);
        spin_vec_t               s;
        int                      field;
        logic signed [BIT_J-1:0] w;
        logic signed [BIT_H-1:0] b;
        s = init;
        for (int n = 0; n < int'(sweeps); n++) begin
            for (int i = 0; i < NUM_SPIN; i++) begin
                b     = h[i*BIT_H +: BIT_H];
                field = int'(b);
                for (int j = 0; j < NUM_SPIN; j++) begin
                    w = j_rows[i][j*BIT_J +: BIT_J];
                    if (j != i) begin
                        field = s[j] ? field + int'(w) : field - int'(w);
                    end
                end
                s[i] = field >= 0;
            end
        end
        return s;
    endfunction

    ////////////////////////////////////////////////////////////
    // AXI4-Lite host
    ////////////////////////////////////////////////////////////
    task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              output axil_resp_e resp);
        int waited;
        @(negedge clk_i);
        axil_req.aw_valid = 1'b1;
        axil_req.aw_addr  = addr;
        axil_req.w_valid  = 1'b1;
        axil_req.w_data   = data;
        axil_req.w_strb   = '1;
        axil_req.b_ready  = 1'b1;
        waited = 0;
        do begin
            @(negedge clk_i);
            waited++;
        end while (!wr_acc_q && waited < TXN_LIMIT);
        axil_req.aw_valid = 1'b0;
        axil_req.w_valid  = 1'b0;
        while (!axil_rsp.b_valid && waited < TXN_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        resp = axil_rsp.b_resp;
        @(negedge clk_i);
        axil_req.b_ready = 1'b0;
        if (waited >= TXN_LIMIT) begin
            $display("write to address %h got no response from the DUT", addr);
            errors++;
        end
    endtask

    task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                             output axil_resp_e resp);
        int waited;
        @(negedge clk_i);
        axil_req.ar_valid = 1'b1;
        axil_req.ar_addr  = addr;
        axil_req.r_ready  = 1'b1;
        waited = 0;
        do begin
            @(negedge clk_i);
            waited++;
        end while (!rd_acc_q && waited < TXN_LIMIT);
        axil_req.ar_valid = 1'b0;
        while (!axil_rsp.r_valid && waited < TXN_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        data = axil_rsp.r_data;
        resp = axil_rsp.r_resp;
        @(negedge clk_i);
        axil_req.r_ready = 1'b0;
        if (waited >= TXN_LIMIT) begin
            $display("read from address %h got no response from the DUT", addr);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////
    task automatic check_resp(input axil_resp_e got, input axil_resp_e exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s response %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_spin(input spin_vec_t got, input spin_vec_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s spins %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_row(input j_row_t got, input j_row_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s row %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequences
    ////////////////////////////////////////////////////////////
    task automatic check_address_map();
        axil_resp_e        resp;
        logic [DATA_W-1:0] rdata;
        axil_read(12'h020, rdata, resp);
        check_resp(resp, SLVERR, "unmapped read");
        axil_write(12'h200, 32'h1234_5678, resp);
        check_resp(resp, SLVERR, "unmapped write");
        axil_read(JMEM_BASE + 12'h002, rdata, resp);
        check_resp(resp, SLVERR, "misaligned J read");
        // SPIN_OUT is read-only so the write is dropped
        axil_write(REG_SPIN_OUT, 32'hFF, resp);
        check_resp(resp, OKAY, "SPIN_OUT write");
    endtask

    task automatic check_busy_refusal();
        axil_resp_e        resp;
        logic [DATA_W-1:0] rdata;
        axil_read(JMEM_BASE + 12'h008, rdata, resp);
        check_resp(resp, SLVERR, "J read while busy");
        axil_write(JMEM_BASE, ~j_rows[0], resp);
        check_resp(resp, SLVERR, "J write while busy");
        axil_read(12'h020, rdata, resp);
        check_resp(resp, SLVERR, "unmapped read while busy");
        axil_read(REG_STATUS, rdata, resp);
        check_word(rdata, 32'h1, "STATUS while busy");
    endtask

    task automatic run_case(input case_t tc, input int idx);
        axil_resp_e        resp;
        logic [DATA_W-1:0] rdata;
        spin_vec_t         exp_spins;
        int                polls;
        for (int i = 0; i < NUM_SPIN; i++) begin
            j_rows[i] = tc.rand_j ? j_row_t'(rand_bits(DATA_W)) : row_pattern(i);
            axil_write(JMEM_BASE + ADDR_W'(4 * i), j_rows[i], resp);
            check_resp(resp, OKAY, "J row write");
        end
        for (int i = 0; i < NUM_SPIN; i++) begin
            axil_read(JMEM_BASE + ADDR_W'(4 * i), rdata, resp);
            check_resp(resp, OKAY, "J row read");
            check_row(rdata, j_rows[i], "J row readback");
        end

        axil_write(REG_SPIN_INIT, DATA_W'(tc.spin_init), resp);
        check_resp(resp, OKAY, "SPIN_INIT write");
        axil_write(REG_H_BIAS, tc.h_bias, resp);
        check_resp(resp, OKAY, "H_BIAS write");
        axil_read(REG_SPIN_INIT, rdata, resp);
        check_resp(resp, OKAY, "SPIN_INIT read");
        check_spin(rdata[NUM_SPIN-1:0], tc.spin_init, "SPIN_INIT readback");
        axil_read(REG_H_BIAS, rdata, resp);
        check_resp(resp, OKAY, "H_BIAS read");
        check_word(rdata, tc.h_bias, "H_BIAS readback");

        exp_spins = model_anneal(tc.spin_init, tc.h_bias, tc.sweeps);
        axil_write(REG_CTRL, {16'h0, tc.sweeps, 8'h01}, resp);
        check_resp(resp, OKAY, "CTRL start");
        // done from the last case must be gone
        if (tc.sweeps != 0) begin
            axil_read(REG_STATUS, rdata, resp);
            check_word(rdata, 32'h1, "STATUS after start");
        end
        if (tc.sweeps > 50) begin
            check_busy_refusal();
        end

        polls = 0;
        do begin
            axil_read(REG_STATUS, rdata, resp);
            polls++;
        end while (!rdata[1] && polls < 2 * NUM_SPIN * int'(tc.sweeps) + 10);
        if (!rdata[1]) begin
            $display("case %0d: anneal never reported done", idx);
            errors++;
        end
        check_word(rdata, 32'h2, "STATUS after done");

        axil_read(REG_SPIN_OUT, rdata, resp);
        check_resp(resp, OKAY, "SPIN_OUT read");
        check_spin(rdata[NUM_SPIN-1:0], exp_spins, "SPIN_OUT");
        if (tc.sweeps == 0) begin
            check_spin(rdata[NUM_SPIN-1:0], tc.spin_init, "SPIN_OUT without sweeps");
        end
        // refused write must not have touched row 0
        if (tc.sweeps > 50) begin
            axil_read(JMEM_BASE, rdata, resp);
            check_row(rdata, j_rows[0], "J row 0 after busy write");
        end
    endtask

    initial begin : stimulus
        clk_i    = 1'b0;
        reset_i  = 1'b1;
        axil_req = '0;
        errors   = 0;
        lfsr_q   = 32'h23c5;
        repeat (2) @(negedge clk_i);
        reset_i = 1'b0;

        check_address_map();
        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(CASE_TBL[c], c);
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: src.f
ising_pkg.sv
axil_slave.sv
ising_regs.sv
coupling_mem.sv
spin_update_engine.sv
ising_core_top.sv
tb_ising_core.sv

// File: run_sim.sh
#!/bin/sh
# build the Ising core testbench with Verilator and run it
# exits non-zero unless the run reports a pass
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_ising_core \
    --Mdir obj_dir -o sim_ising
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_ising)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if echo "$out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1
